//--- rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and microcode widths
`define NIBBLE_W 4
`define OPCODE_W 7
`define UPC_W 8
`define UWORD_W 16
`define FIELD_W 3

// Microword layout
`define UOP_MSB 15
`define UOP_LSB 13
`define SRC_MSB 12
`define SRC_LSB 10
`define ALUOP_MSB 12
`define ALUOP_LSB 10
`define DST_MSB 9
`define DST_LSB 7
`define FLAGW_BIT 6
`define JCOND_BIT 12
`define JFLAG_BIT 11
`define JPOL_BIT 10
`define JTGT_MSB 7
`define JTGT_LSB 0

// Macro opcodes, start address is opcode << 1
`define OP_LDA 7'h01
`define OP_LDB 7'h02
`define OP_ADD 7'h03
`define OP_SUB 7'h04
`define OP_AND 7'h05
`define OP_XOR 7'h06
`define OP_MOVBA 7'h07
`define OP_SATZ 7'h08
`define OP_HALT 7'h0f

// SATZ continuation words, odd slots of unused opcodes
`define SATZ_SAT_ADDR 8'h81
`define SATZ_ADD_ADDR 8'h83

`endif

//--- rtl/cpu_types_pkg.sv
`include "cpu_consts.svh"

package cpu_types_pkg;

  typedef logic [`NIBBLE_W-1:0] nibble_t;
  typedef logic [`OPCODE_W-1:0] opcode_t;
  typedef logic [`UPC_W-1:0] upc_t;
  typedef logic [`UWORD_W-1:0] uword_t;

  // Microword opcode field
  typedef enum logic [`UOP_MSB-`UOP_LSB:0] {
    NOP,
    TRANSFER,
    TRANSALU,
    JMP,
    END,
    HALT
  } uop_t;

  // Bus sources and destinations
  typedef enum logic [`FIELD_W-1:0] {
    REG_NONE,
    REG_A,
    REG_B,
    REG_IMM,
    REG_ALU,
    REG_ALU_WITH_FLAGS,
    REG_CONST_F
  } bus_reg_t;

  typedef enum logic [`FIELD_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    EXEC,
    HALTED
  } seq_stage_t;

endpackage

//--- rtl/microcode_rom.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module microcode_rom (
  input  cpu_types_pkg::upc_t   upc,
  output cpu_types_pkg::uword_t uword
);
  import cpu_types_pkg::*;

  function automatic uword_t xfer(bus_reg_t src, bus_reg_t dst);
    uword_t w;
    w = '0;
    w[`UOP_MSB:`UOP_LSB] = TRANSFER;
    w[`SRC_MSB:`SRC_LSB] = src;
    w[`DST_MSB:`DST_LSB] = dst;
    return w;
  endfunction

  // ALU result onto the bus, flags written as well
  function automatic uword_t alu_word(alu_op_t op, bus_reg_t dst);
    uword_t w;
    w = '0;
    w[`UOP_MSB:`UOP_LSB] = TRANSALU;
    w[`ALUOP_MSB:`ALUOP_LSB] = op;
    w[`DST_MSB:`DST_LSB] = dst;
    w[`FLAGW_BIT] = 1'b1;
    return w;
  endfunction

  function automatic uword_t jmp(logic cond, logic on_carry, logic pol, upc_t target);
    uword_t w;
    w = '0;
    w[`UOP_MSB:`UOP_LSB] = JMP;
    w[`JCOND_BIT] = cond;
    w[`JFLAG_BIT] = on_carry;
    w[`JPOL_BIT] = pol;
    w[`JTGT_MSB:`JTGT_LSB] = target;
    return w;
  endfunction

  function automatic uword_t plain(uop_t op);
    uword_t w;
    w = '0;
    w[`UOP_MSB:`UOP_LSB] = op;
    return w;
  endfunction

  always_comb begin
    case (upc)
      {`OP_LDA, 1'b0}:   uword = xfer(REG_IMM, REG_A);
      {`OP_LDB, 1'b0}:   uword = xfer(REG_IMM, REG_B);
      {`OP_ADD, 1'b0}:   uword = alu_word(ALU_ADD, REG_A);
      {`OP_SUB, 1'b0}:   uword = alu_word(ALU_SUB, REG_A);
      {`OP_AND, 1'b0}:   uword = alu_word(ALU_AND, REG_A);
      {`OP_XOR, 1'b0}:   uword = alu_word(ALU_XOR, REG_A);
      {`OP_MOVBA, 1'b0}: uword = xfer(REG_A, REG_B);
      // SATZ branches on zero, the even slot after each target is an END
      {`OP_SATZ, 1'b0}:  uword = jmp(1'b1, 1'b0, 1'b1, `SATZ_SAT_ADDR);
      {`OP_SATZ, 1'b1}:  uword = jmp(1'b0, 1'b0, 1'b0, `SATZ_ADD_ADDR);
      `SATZ_SAT_ADDR:    uword = xfer(REG_CONST_F, REG_A);
      `SATZ_ADD_ADDR:    uword = alu_word(ALU_ADD, REG_A);
      {`OP_HALT, 1'b0}:  uword = plain(HALT);
      default:           uword = plain(END);
    endcase
  end

endmodule

//--- rtl/microcode_sequencer.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module microcode_sequencer (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     instr_valid,
  input  cpu_types_pkg::opcode_t   instr_opcode,
  input  cpu_types_pkg::uword_t    uword,
  input  logic                     flag_zero,
  input  logic                     flag_carry,
  output cpu_types_pkg::upc_t      upc,
  output cpu_types_pkg::bus_reg_t  bus_src,
  output cpu_types_pkg::bus_reg_t  bus_dst,
  output cpu_types_pkg::alu_op_t   alu_operation,
  output logic                     flag_write,
  output logic                     done,
  output logic                     halted
);
  import cpu_types_pkg::*;

  seq_stage_t stage;
  uop_t       uop;
  logic       jump_flag;
  logic       jump_taken;

  // Microword decode, valid while upc is stable in FETCH
  always_comb begin
    uop = uop_t'(uword[`UOP_MSB:`UOP_LSB]);
    jump_flag = uword[`JFLAG_BIT] ? flag_carry : flag_zero;
    jump_taken = !uword[`JCOND_BIT] || (jump_flag == uword[`JPOL_BIT]);
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stage <= IDLE;
      upc <= '0;
      // Bus parked on the immediate while idle
      bus_src <= REG_IMM;
      bus_dst <= REG_NONE;
      alu_operation <= ALU_ADD;
      flag_write <= 1'b0;
      done <= 1'b0;
      halted <= 1'b0;
    end else begin
      case (stage)
        IDLE: begin
          if (instr_valid) begin
            upc <= {instr_opcode, 1'b0};
            bus_src <= REG_NONE;
            stage <= FETCH;
          end
        end

        FETCH: begin
          // Controls registered here are live for the whole EXEC cycle
          stage <= EXEC;
          upc <= upc + 1'b1;
          case (uop)
            TRANSFER: begin
              bus_src <= bus_reg_t'(uword[`SRC_MSB:`SRC_LSB]);
              bus_dst <= bus_reg_t'(uword[`DST_MSB:`DST_LSB]);
            end
            TRANSALU: begin
              alu_operation <= alu_op_t'(uword[`ALUOP_MSB:`ALUOP_LSB]);
              bus_src <= uword[`FLAGW_BIT] ? REG_ALU_WITH_FLAGS : REG_ALU;
              bus_dst <= bus_reg_t'(uword[`DST_MSB:`DST_LSB]);
              flag_write <= uword[`FLAGW_BIT];
            end
            JMP: begin
              if (jump_taken) begin
                upc <= uword[`JTGT_MSB:`JTGT_LSB];
              end
            end
            END: begin
              done <= 1'b1;
            end
            HALT: begin
              halted <= 1'b1;
              stage <= HALTED;
            end
            default: begin
            end
          endcase
        end

        EXEC: begin
          // Register bus writes at the end of this cycle
          bus_src <= REG_NONE;
          bus_dst <= REG_NONE;
          flag_write <= 1'b0;
          if (done) begin
            done <= 1'b0;
            bus_src <= REG_IMM;
            stage <= IDLE;
          end else begin
            stage <= FETCH;
          end
        end

        default: begin
          // Stuck here until reset
          stage <= HALTED;
        end
      endcase
    end
  end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu (
  input  cpu_types_pkg::nibble_t  operand_a,
  input  cpu_types_pkg::nibble_t  operand_b,
  input  cpu_types_pkg::alu_op_t  alu_operation,
  output cpu_types_pkg::nibble_t  alu_result,
  output logic                    alu_carry,
  output logic                    alu_zero
);
  import cpu_types_pkg::*;

  // One extra bit for carry out or borrow
  logic [`NIBBLE_W:0] sum;

  always_comb begin
    sum = '0;
    alu_carry = 1'b0;
    case (alu_operation)
      ALU_ADD: begin
        sum = {1'b0, operand_a} + {1'b0, operand_b};
        alu_carry = sum[`NIBBLE_W];
      end
      ALU_SUB: begin
        // Top bit set on borrow
        sum = {1'b0, operand_a} - {1'b0, operand_b};
        alu_carry = sum[`NIBBLE_W];
      end
      ALU_AND: begin
        sum = {1'b0, operand_a & operand_b};
      end
      ALU_XOR: begin
        sum = {1'b0, operand_a ^ operand_b};
      end
      ALU_PASS_B: begin
        sum = {1'b0, operand_b};
      end
      default: begin
        sum = '0;
      end
    endcase
    alu_result = sum[`NIBBLE_W-1:0];
    alu_zero = (alu_result == '0);
  end

endmodule

//--- rtl/register_bus.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module register_bus (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     instr_valid,
  input  cpu_types_pkg::nibble_t   instr_imm,
  input  cpu_types_pkg::bus_reg_t  bus_src,
  input  cpu_types_pkg::bus_reg_t  bus_dst,
  input  logic                     flag_write,
  input  cpu_types_pkg::nibble_t   alu_result,
  input  logic                     alu_carry,
  input  logic                     alu_zero,
  output cpu_types_pkg::nibble_t   operand_a,
  output cpu_types_pkg::nibble_t   operand_b,
  output logic                     flag_zero,
  output logic                     flag_carry
);
  import cpu_types_pkg::*;

  nibble_t reg_a_q;
  nibble_t reg_b_q;
  nibble_t imm_q;
  nibble_t bus_value;
  logic    imm_load;

  // Sequencer parks the bus on the immediate only when idle
  assign imm_load = instr_valid && (bus_src == REG_IMM) && (bus_dst == REG_NONE);

  always_comb begin
    case (bus_src)
      REG_A:                      bus_value = reg_a_q;
      REG_B:                      bus_value = reg_b_q;
      REG_IMM:                    bus_value = imm_q;
      REG_ALU, REG_ALU_WITH_FLAGS: bus_value = alu_result;
      REG_CONST_F:                bus_value = {`NIBBLE_W{1'b1}};
      default:                    bus_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (imm_load) begin
      imm_q <= instr_imm;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      reg_a_q <= '0;
      reg_b_q <= '0;
      flag_zero <= 1'b0;
      flag_carry <= 1'b0;
    end else begin
      case (bus_dst)
        REG_A: reg_a_q <= bus_value;
        REG_B: reg_b_q <= bus_value;
        default: begin
        end
      endcase
      if (flag_write) begin
        flag_zero <= alu_zero;
        flag_carry <= alu_carry;
      end
    end
  end

  assign operand_a = reg_a_q;
  assign operand_b = reg_b_q;

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    instr_valid,
  input  cpu_types_pkg::opcode_t  instr_opcode,
  input  cpu_types_pkg::nibble_t  instr_imm,
  output cpu_types_pkg::nibble_t  reg_a,
  output cpu_types_pkg::nibble_t  reg_b,
  output logic                    flag_zero,
  output logic                    flag_carry,
  output logic                    done,
  output logic                    halted
);
  import cpu_types_pkg::*;

  upc_t     upc;
  uword_t   uword;
  bus_reg_t bus_src;
  bus_reg_t bus_dst;
  alu_op_t  alu_operation;
  logic     flag_write;
  nibble_t  operand_a;
  nibble_t  operand_b;
  nibble_t  alu_result;
  logic     alu_carry;
  logic     alu_zero;

  microcode_sequencer i_sequencer (
    .clk           (clk),
    .reset_n       (reset_n),
    .instr_valid   (instr_valid),
    .instr_opcode  (instr_opcode),
    .uword         (uword),
    .flag_zero     (flag_zero),
    .flag_carry    (flag_carry),
    .upc           (upc),
    .bus_src       (bus_src),
    .bus_dst       (bus_dst),
    .alu_operation (alu_operation),
    .flag_write    (flag_write),
    .done          (done),
    .halted        (halted)
  );

  microcode_rom i_rom (
    .upc   (upc),
    .uword (uword)
  );

  alu i_alu (
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .alu_operation (alu_operation),
    .alu_result    (alu_result),
    .alu_carry     (alu_carry),
    .alu_zero      (alu_zero)
  );

  register_bus i_register_bus (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr_valid (instr_valid),
    .instr_imm   (instr_imm),
    .bus_src     (bus_src),
    .bus_dst     (bus_dst),
    .flag_write  (flag_write),
    .alu_result  (alu_result),
    .alu_carry   (alu_carry),
    .alu_zero    (alu_zero),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .flag_zero   (flag_zero),
    .flag_carry  (flag_carry)
  );

  // Register file is visible straight from the ALU operands
  assign reg_a = operand_a;
  assign reg_b = operand_b;

endmodule

//--- bench/cpu_core_properties.sv
`timescale 1ns/1ns

module cpu_core_properties (
  input logic  clk,
  input logic  reset_n,
  input logic  done,
  input logic  halted
);

  int unsigned failures = 0;

  // Done is a single-cycle strobe
  done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
    else begin
      failures++;
      $error("done stayed high for two cycles");
    end

  // Only reset leaves the halted state
  halted_sticky: assert property (@(posedge clk) disable iff (!reset_n) halted |=> halted)
    else begin
      failures++;
      $error("halted dropped without reset");
    end

  done_halted_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
                                          !(done && halted))
    else begin
      failures++;
      $error("done and halted high together");
    end

endmodule

bind microcode_sequencer cpu_core_properties i_properties (
  .clk     (clk),
  .reset_n (reset_n),
  .done    (done),
  .halted  (halted)
);

//--- bench/cpu_core_tb.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_core_tb;
  import cpu_types_pkg::*;

  typedef struct packed {
    nibble_t a;
    nibble_t b;
    logic    zero;
    logic    carry;
  } model_t;

  localparam int unsigned WAIT_LIMIT = 50;

  logic    clk;
  logic    reset_n;
  logic    instr_valid;
  opcode_t instr_opcode;
  nibble_t instr_imm;
  nibble_t reg_a;
  nibble_t reg_b;
  logic    flag_zero;
  logic    flag_carry;
  logic    done;
  logic    halted;

  integer      seed;
  int unsigned cycle = 0;
  int unsigned error_count = 0;
  int unsigned errors_at_start = 0;
  int unsigned check_count = 0;
  int unsigned tests_run = 0;
  int unsigned failed_tests = 0;
  int unsigned done_count = 0;
  int unsigned strobe_cycle = 0;
  int unsigned expected_latency = 0;
  logic        timed_out = 1'b0;
  logic        pending = 1'b0;
  model_t      model = '0;

  cpu_core i_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .instr_valid  (instr_valid),
    .instr_opcode (instr_opcode),
    .instr_imm    (instr_imm),
    .reg_a        (reg_a),
    .reg_b        (reg_b),
    .flag_zero    (flag_zero),
    .flag_carry   (flag_carry),
    .done         (done),
    .halted       (halted)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Macro-instruction semantics on the A, B and flag model
  function automatic model_t reference_step(model_t s, opcode_t op, nibble_t imm);
    model_t n;
    int     total;
    n = s;
    total = int'(s.a) + int'(s.b);
    case (op)
      `OP_LDA: n.a = imm;
      `OP_LDB: n.b = imm;
      `OP_MOVBA: n.b = s.a;
      `OP_ADD, `OP_SATZ: begin
        if (op == `OP_SATZ && s.zero) begin
          n.a = 4'hf;
        end else begin
          n.a = nibble_t'(total % 16);
          n.carry = (total > 15);
          n.zero = (total % 16 == 0);
        end
      end
      `OP_SUB: begin
        n.a = s.a - s.b;
        n.carry = (s.a < s.b);
        n.zero = (s.a == s.b);
      end
      `OP_AND, `OP_XOR: begin
        n.a = (op == `OP_AND) ? (s.a & s.b) : (s.a ^ s.b);
        n.carry = 1'b0;
        n.zero = (n.a == 4'h0);
      end
      default: begin
      end
    endcase
    return n;
  endfunction

  // Two cycles per microword
  function automatic int unsigned latency_of(opcode_t op, logic zero);
    case (op)
      `OP_LDA, `OP_LDB, `OP_MOVBA: return 4;
      `OP_ADD, `OP_SUB, `OP_AND, `OP_XOR: return 4;
      `OP_SATZ: return zero ? 6 : 8;
      default: return 2;
    endcase
  endfunction

  function automatic opcode_t pick_alu_op();
    int unsigned r;
    r = $unsigned($random(seed)) % 4;
    case (r)
      0: return `OP_ADD;
      1: return `OP_SUB;
      2: return `OP_AND;
      default: return `OP_XOR;
    endcase
  endfunction

  task automatic report_mismatch(string what, int got, int expected);
    error_count++;
    $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
  endtask

  task automatic compare_registers();
    check_count++;
    assert (reg_a == model.a)
      else report_mismatch("reg_a", int'(reg_a), int'(model.a));
    assert (reg_b == model.b)
      else report_mismatch("reg_b", int'(reg_b), int'(model.b));
    assert (flag_zero == model.zero)
      else report_mismatch("flag_zero", int'(flag_zero), int'(model.zero));
    assert (flag_carry == model.carry)
      else report_mismatch("flag_carry", int'(flag_carry), int'(model.carry));
  endtask

  task automatic check_outputs(logic exp_halted);
    compare_registers();
    assert (done == 1'b0)
      else report_mismatch("done", int'(done), 0);
    assert (halted == exp_halted)
      else report_mismatch("halted", int'(halted), int'(exp_halted));
  endtask

  // Compare on every done pulse
  always @(negedge clk) begin
    if (reset_n && done) begin
      assert (pending)
        else begin
          error_count++;
          $display("Unexpected done pulse at %0t ns with no instruction in flight", $time);
        end
      if (pending) begin
        compare_registers();
        assert (cycle - strobe_cycle == expected_latency)
          else report_mismatch("done latency", int'(cycle - strobe_cycle),
                               int'(expected_latency));
      end
      pending = 1'b0;
      done_count++;
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    reset_n = 1'b0;
    instr_valid = 1'b0;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    model = '0;
    pending = 1'b0;
  endtask

  task automatic run_instruction(opcode_t op, nibble_t imm, logic busy_strobe);
    int unsigned start;
    int unsigned waited;
    if (timed_out) return;
    @(negedge clk);
    expected_latency = latency_of(op, model.zero);
    model = reference_step(model, op, imm);
    strobe_cycle = cycle;
    start = done_count;
    pending = 1'b1;
    instr_valid = 1'b1;
    instr_opcode = op;
    instr_imm = imm;
    @(negedge clk);
    instr_valid = 1'b0;
    if (busy_strobe) begin
      // Second strobe lands while the core is busy
      @(negedge clk);
      instr_valid = 1'b1;
      instr_opcode = pick_alu_op();
      instr_imm = nibble_t'($random(seed));
      @(negedge clk);
      instr_valid = 1'b0;
    end
    waited = 0;
    while (done_count == start && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (done_count == start) begin
      timed_out = 1'b1;
      $display("Timed out after %0d cycles waiting for done of opcode %h", WAIT_LIMIT, op);
    end
  endtask

  task automatic run_halt_test();
    int unsigned start;
    int unsigned waited;
    opcode_t     after_halt[3];
    int          i;
    after_halt = '{`OP_LDA, `OP_LDB, `OP_ADD};
    if (timed_out) return;
    @(negedge clk);
    start = cycle;
    instr_valid = 1'b1;
    instr_opcode = `OP_HALT;
    @(negedge clk);
    instr_valid = 1'b0;
    waited = 1;
    while (!halted && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!halted) begin
      timed_out = 1'b1;
      $display("Timed out after %0d cycles waiting for halted", WAIT_LIMIT);
      return;
    end
    assert (cycle - start == 2)
      else report_mismatch("halt latency", int'(cycle - start), 2);
    // Strobes while halted change nothing
    for (i = 0; i < 3; i++) begin
      @(negedge clk);
      instr_valid = 1'b1;
      instr_opcode = after_halt[i];
      instr_imm = nibble_t'($random(seed));
      repeat (8) begin
        @(negedge clk);
        instr_valid = 1'b0;
        check_outputs(1'b1);
      end
    end
    apply_reset();
    repeat (4) begin
      @(negedge clk);
      check_outputs(1'b0);
    end
    run_instruction(`OP_LDA, nibble_t'($random(seed)), 1'b0);
  endtask

  task automatic close_test(string name);
    tests_run++;
    if (error_count == errors_at_start && !timed_out) begin
      $display("Test %0d %s: pass", tests_run, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: fail, %0d errors", tests_run, name,
               error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  initial begin
    int      i;
    nibble_t a;
    nibble_t b;
    seed = 32'h1028;
    clk = 1'b0;
    reset_n = 1'b0;
    instr_valid = 1'b0;
    instr_opcode = '0;
    instr_imm = '0;
    apply_reset();

    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      check_outputs(1'b0);
    end
    close_test("reset and idle");

    run_instruction(`OP_LDA, nibble_t'($random(seed)), 1'b0);
    run_instruction(`OP_LDB, nibble_t'($random(seed)), 1'b0);
    run_instruction(`OP_MOVBA, 4'h0, 1'b0);
    run_instruction(`OP_LDA, nibble_t'($random(seed)), 1'b0);
    // Unused opcode runs a lone END
    run_instruction(7'h30, 4'h9, 1'b0);
    close_test("loads and move");

    for (i = 0; i < 200; i++) begin
      run_instruction(`OP_LDA, nibble_t'($random(seed)), 1'b0);
      run_instruction(`OP_LDB, nibble_t'($random(seed)), 1'b0);
      run_instruction(pick_alu_op(), 4'h0, 1'b0);
    end
    close_test("random alu");

    // Saturate path, then add path
    run_instruction(`OP_LDA, 4'h5, 1'b0);
    run_instruction(`OP_LDB, 4'h5, 1'b0);
    run_instruction(`OP_SUB, 4'h0, 1'b0);
    run_instruction(`OP_SATZ, 4'h0, 1'b0);
    run_instruction(`OP_LDA, 4'h3, 1'b0);
    run_instruction(`OP_LDB, 4'h4, 1'b0);
    run_instruction(`OP_ADD, 4'h0, 1'b0);
    run_instruction(`OP_SATZ, 4'h0, 1'b0);
    for (i = 0; i < 16; i++) begin
      a = nibble_t'($random(seed));
      b = i[0] ? a : nibble_t'($random(seed));
      run_instruction(`OP_LDA, a, 1'b0);
      run_instruction(`OP_LDB, b, 1'b0);
      run_instruction(`OP_XOR, 4'h0, 1'b0);
      run_instruction(`OP_SATZ, 4'h0, 1'b0);
    end
    close_test("satz paths");

    for (i = 0; i < 20; i++) begin
      run_instruction(`OP_LDA, nibble_t'($random(seed)), 1'b1);
      run_instruction(`OP_LDB, nibble_t'($random(seed)), 1'b1);
      run_instruction(pick_alu_op(), 4'h0, 1'b1);
    end
    close_test("busy strobes");

    run_halt_test();
    close_test("halt");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d property failures",
             tests_run, failed_tests, check_count, error_count,
             i_dut.i_sequencer.i_properties.failures);
    if (error_count == 0 && failed_tests == 0 && !timed_out &&
        i_dut.i_sequencer.i_properties.failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/microcode_rom.sv
rtl/microcode_sequencer.sv
rtl/alu.sv
rtl/register_bus.sv
rtl/cpu_core.sv
bench/cpu_core_properties.sv
bench/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cpu_types_pkg.sv
      - rtl/microcode_rom.sv
      - rtl/microcode_sequencer.sv
      - rtl/alu.sv
      - rtl/register_bus.sv
      - rtl/cpu_core.sv
  - target: test
    files:
      - bench/cpu_core_properties.sv
      - bench/cpu_core_tb.sv
